//--- ex_pkg.sv
// shared widths and encodings for the execute stage; func codes are 5 bits so all sixteen ops plus the default fit
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////
    // datapath and tag widths
    ////////////////////////////////////////

    localparam int xlen    = 64;            // integer datapath
    localparam int shamt_w = $clog2(xlen);  // shift amount taken from low bits of opb
    localparam int tag_w   = 6;             // 64-entry physical register file
    localparam int rob_w   = 5;             // 32-entry reorder buffer
    localparam int num_fu  = 4;             // mult1, alu1, mult2, alu2

    ////////////////////////////////////////
    // alu function codes
    ////////////////////////////////////////

    // alpha-style integer ops
    typedef enum logic [4:0] {
        // arithmetic
        alu_addq    = 5'h00,
        alu_subq    = 5'h01,
        // bitwise
        alu_and     = 5'h02,
        alu_bic     = 5'h03,  // and with complement
        alu_bis     = 5'h04,  // plain or
        alu_ornot   = 5'h05,
        alu_xor     = 5'h06,
        alu_eqv     = 5'h07,  // xnor
        // shifts
        alu_srl     = 5'h08,
        alu_sll     = 5'h09,
        alu_sra     = 5'h0a,
        // compares, result is 0 or 1
        alu_cmpult  = 5'h0b,
        alu_cmpeq   = 5'h0c,
        alu_cmpule  = 5'h0d,
        alu_cmplt   = 5'h0e,  // signed
        alu_cmple   = 5'h0f,  // signed
        // reset value of the func outputs
        alu_default = 5'h1f
    } alu_func_e;

    ////////////////////////////////////////
    // functional unit kinds
    ////////////////////////////////////////

    // picks the compute block inside exec_unit
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_kind_e;

endpackage

`default_nettype wire

//--- fu_if.sv
// issue, result and grant signals of one execution unit; carries no clock, issue only while available is high
`timescale 1ns/1ps
`default_nettype none

interface fu_if
    import ex_pkg::*;
();

    // issue side, from the reservation station
    logic             issue_valid;  // one-cycle pulse
    logic [xlen-1:0]  opa;
    logic [xlen-1:0]  opb;
    logic [tag_w-1:0] dest_tag;
    logic [rob_w-1:0] rob_idx;
    alu_func_e        func;

    // result side, held until granted
    logic             result_valid;
    logic [xlen-1:0]  result;
    logic [tag_w-1:0] dest_tag_out;
    logic [rob_w-1:0] rob_idx_out;
    alu_func_e        func_out;
    logic             available;    // combinational

    // cdb grant for the held result
    logic             grant;

    // the execution unit itself
    modport unit (
        input  issue_valid, opa, opb, dest_tag, rob_idx, func, grant,
        output result_valid, result, dest_tag_out, rob_idx_out, func_out, available
    );

    // stage side, drives issue and grant
    modport stage (
        output issue_valid, opa, opb, dest_tag, rob_idx, func, grant,
        input  result_valid, result, dest_tag_out, rob_idx_out, func_out, available
    );

endinterface

`default_nettype wire

//--- alu.sv
// purely combinational 64-bit integer alu; shifts use the low 6 bits of opb, unknown codes give zero
`timescale 1ns/1ps
`default_nettype none

module alu
    import ex_pkg::*;
(
    input  logic [xlen-1:0] opa,
    input  logic [xlen-1:0] opb,
    input  alu_func_e       func,
    output logic [xlen-1:0] result
);

    logic [shamt_w-1:0] shamt;       // shift distance
    logic [shamt_w:0]   fill_shamt;  // where sign fill starts for sra
    logic               lt_s;        // signed opa < opb
    logic               lt_u;        // unsigned opa < opb
    logic               eq;

    // signed less-than from unsigned compare
    function automatic logic signed_lt(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        if (a[xlen-1] == b[xlen-1])
        begin
            return a < b;        // same sign, unsigned order holds
        end
        else
        begin
            return a[xlen-1];    // negative one is smaller
        end
    endfunction

    assign shamt      = opb[shamt_w-1:0];
    assign fill_shamt = (shamt_w + 1)'(xlen) - {1'b0, shamt};  // xlen when shamt is 0
    assign lt_s       = signed_lt(opa, opb);
    assign lt_u       = opa < opb;
    assign eq         = opa == opb;

    ////////////////////////////////////////
    // function select
    ////////////////////////////////////////

    always_comb
    begin
        case (func)
            alu_addq:    result = opa + opb;
            alu_subq:    result = opa - opb;
            alu_and:     result = opa & opb;
            alu_bic:     result = opa & ~opb;
            alu_bis:     result = opa | opb;
            alu_ornot:   result = opa | ~opb;
            alu_xor:     result = opa ^ opb;
            alu_eqv:     result = opa ^ ~opb;
            alu_srl:     result = opa >> shamt;
            alu_sll:     result = opa << shamt;
            // logical shift, then sign bits filled in from the top
            alu_sra:     result = (opa >> shamt) | ({xlen{opa[xlen-1]}} << fill_shamt);
            alu_cmpult:  result = xlen'(lt_u);
            alu_cmpeq:   result = xlen'(eq);
            alu_cmpule:  result = xlen'(lt_u | eq);
            alu_cmplt:   result = xlen'(lt_s);
            alu_cmple:   result = xlen'(lt_s | eq);
            alu_default: result = '0;
            default:     result = '0;   // unused codes
        endcase
    end

endmodule

`default_nettype wire

//--- mult.sv
// pipelined multiplier giving the low 64 bits of the product; MULT_STAGES must divide 64 and done comes MULT_STAGES edges after start
`timescale 1ns/1ps
`default_nettype none

module mult
    import ex_pkg::*;
#(
    parameter int MULT_STAGES = 4
)
(
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    input  logic [xlen-1:0] mcand,
    input  logic [xlen-1:0] mplier,
    output logic [xlen-1:0] product,
    output logic            done
);

    localparam int stage_bits = xlen / MULT_STAGES;  // multiplier bits per stage
    localparam logic [xlen-1:0] digit_mask = {xlen{1'b1}} >> (xlen - stage_bits);

    // index 0 is the input register and 1..MULT_STAGES the compute stages
    logic [MULT_STAGES:0] valid_q;
    logic [xlen-1:0]      mcand_q  [MULT_STAGES];     // shifted left each stage
    logic [xlen-1:0]      mplier_q [MULT_STAGES];     // shifted right each stage
    logic [xlen-1:0]      prod_q   [1:MULT_STAGES];   // running partial sum

    ////////////////////////////////////////
    // valid chain
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= {valid_q[MULT_STAGES-1:0], start};  // one op per cycle possible
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        mcand_q[0]  <= mcand;
        mplier_q[0] <= mplier;
        prod_q[1]   <= mcand_q[0] * (mplier_q[0] & digit_mask);  // first digit starts the sum
        for (int s = 1; s < MULT_STAGES; s++)
        begin
            // add mcand times the low digit of the remaining multiplier
            prod_q[s+1] <= prod_q[s] + mcand_q[s] * (mplier_q[s] & digit_mask);
            mcand_q[s]  <= mcand_q[s-1] << stage_bits;   // next digit weight
            mplier_q[s] <= mplier_q[s-1] >> stage_bits;  // drop used digit
        end
    end

    assign product = prod_q[MULT_STAGES];  // valid with done
    assign done    = valid_q[MULT_STAGES];

endmodule

`default_nettype wire

//--- exec_unit.sv
// one functional unit, alu or multiplier; holds its result until granted, a multiplier takes one op at a time
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import ex_pkg::*;
#(
    parameter fu_kind_e UNIT_KIND   = fu_alu,
    parameter int       MULT_STAGES = 4
)
(
    input  logic clock,
    input  logic reset,
    fu_if.unit   port
);

    // held result and tags
    logic             result_valid_q;
    logic [xlen-1:0]  result_q;
    logic [tag_w-1:0] dest_tag_q;
    logic [rob_w-1:0] rob_idx_q;
    alu_func_e        func_q;
    logic             busy_q;        // multiply in flight

    // from the compute block
    logic             unit_done;     // load result this edge
    logic [xlen-1:0]  unit_result;
    logic             mult_start;    // sets busy

    ////////////////////////////////////////
    // compute block by kind
    ////////////////////////////////////////

    generate
        if (UNIT_KIND == fu_mult)
        begin : g_mult
            logic [xlen-1:0] product;
            logic            done;

            mult #(
                .MULT_STAGES (MULT_STAGES)
            ) mult_inst (
                .clock   (clock),
                .reset   (reset),
                .start   (port.issue_valid),
                .mcand   (port.opa),
                .mplier  (port.opb),
                .product (product),
                .done    (done)
            );

            assign mult_start  = port.issue_valid;
            assign unit_done   = done;           // registered one edge later
            assign unit_result = product;
        end
        else
        begin : g_alu
            logic [xlen-1:0] alu_result;

            alu alu_inst (
                .opa    (port.opa),
                .opb    (port.opb),
                .func   (port.func),
                .result (alu_result)
            );

            assign mult_start  = 1'b0;           // never busy
            assign unit_done   = port.issue_valid;  // result on the issue edge
            assign unit_result = alu_result;
        end
    endgenerate

    ////////////////////////////////////////
    // result hold and busy
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            result_valid_q <= 1'b0;
            result_q       <= '0;
            dest_tag_q     <= '0;
            rob_idx_q      <= '0;
            func_q         <= alu_default;
            busy_q         <= 1'b0;
        end
        else
        begin
            if (port.issue_valid)
            begin
                dest_tag_q <= port.dest_tag;   // tags follow the op
                rob_idx_q  <= port.rob_idx;
                func_q     <= port.func;
            end
            if (unit_done)
            begin
                result_q       <= unit_result;
                result_valid_q <= 1'b1;        // alu reissue keeps it high
            end
            else if (port.issue_valid || port.grant)
            begin
                result_valid_q <= 1'b0;        // granted, or mult restarted
            end
            if (mult_start)
            begin
                busy_q <= 1'b1;
            end
            else if (unit_done)
            begin
                busy_q <= 1'b0;
            end
        end
    end

    // free when the held result leaves this cycle, or when idle
    assign port.available    = result_valid_q ? port.grant : ~busy_q;
    assign port.result_valid = result_valid_q;
    assign port.result       = result_q;
    assign port.dest_tag_out = dest_tag_q;
    assign port.rob_idx_out  = rob_idx_q;
    assign port.func_out     = func_q;

endmodule

`default_nettype wire

//--- ex_stage.sv
// execute stage with four units (mult, alu, mult, alu); no added latency, issue a unit only while its available is high
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
#(
    parameter int MULT_STAGES = 4
)
(
    input  logic                              clock,
    input  logic                              reset,

    // issue from the reservation stations
    input  logic      [num_fu-1:0]             issue_valid,
    input  logic      [num_fu-1:0][xlen-1:0]   issue_opa,
    input  logic      [num_fu-1:0][xlen-1:0]   issue_opb,
    input  logic      [num_fu-1:0][tag_w-1:0]  issue_dest_tag,
    input  logic      [num_fu-1:0][rob_w-1:0]  issue_rob_idx,
    input  alu_func_e [num_fu-1:0]             issue_func,

    // cdb grant per unit
    input  logic      [num_fu-1:0]             grant,

    // held results toward the cdb
    output logic      [num_fu-1:0]             result_valid,
    output logic      [num_fu-1:0][xlen-1:0]   result,
    output logic      [num_fu-1:0][tag_w-1:0]  result_dest_tag,
    output logic      [num_fu-1:0][rob_w-1:0]  result_rob_idx,
    output alu_func_e [num_fu-1:0]             result_func,
    output logic      [num_fu-1:0]             available
);

    // unit order mult1, alu1, mult2, alu2
    localparam fu_kind_e unit_kind [num_fu] = '{fu_mult, fu_alu, fu_mult, fu_alu};

    fu_if fu_bus [num_fu] ();

    ////////////////////////////////////////
    // per-unit wiring
    ////////////////////////////////////////

    for (genvar i = 0; i < num_fu; i++)
    begin : g_fu
        // issue and grant in
        assign fu_bus[i].issue_valid = issue_valid[i];
        assign fu_bus[i].opa         = issue_opa[i];
        assign fu_bus[i].opb         = issue_opb[i];
        assign fu_bus[i].dest_tag    = issue_dest_tag[i];
        assign fu_bus[i].rob_idx     = issue_rob_idx[i];
        assign fu_bus[i].func        = issue_func[i];
        assign fu_bus[i].grant       = grant[i];

        exec_unit #(
            .UNIT_KIND   (unit_kind[i]),
            .MULT_STAGES (MULT_STAGES)
        ) exec_unit_inst (
            .clock (clock),
            .reset (reset),
            .port  (fu_bus[i])
        );

        // results out, straight from the unit registers
        assign result_valid[i]    = fu_bus[i].result_valid;
        assign result[i]          = fu_bus[i].result;
        assign result_dest_tag[i] = fu_bus[i].dest_tag_out;
        assign result_rob_idx[i]  = fu_bus[i].rob_idx_out;
        assign result_func[i]     = fu_bus[i].func_out;
        assign available[i]       = fu_bus[i].available;  // combinational through grant
    end

endmodule

`default_nettype wire

//--- ex_stage_tb.sv
// runs ex_stage with four mult stages and checks every negedge against a cycle model; a timeout ends the run
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int mult_stages    = 4;
    localparam int timeout_cycles = 200;  // per wait loop
    localparam int num_ops        = 16;

    logic                             clock = 1'b0;
    logic                             reset;
    logic      [num_fu-1:0]           issue_valid;
    logic      [num_fu-1:0][xlen-1:0] issue_opa;
    logic      [num_fu-1:0][xlen-1:0] issue_opb;
    logic      [num_fu-1:0][tag_w-1:0] issue_dest_tag;
    logic      [num_fu-1:0][rob_w-1:0] issue_rob_idx;
    alu_func_e [num_fu-1:0]           issue_func;
    logic      [num_fu-1:0]           grant;
    logic      [num_fu-1:0]           result_valid;
    logic      [num_fu-1:0][xlen-1:0] result;
    logic      [num_fu-1:0][tag_w-1:0] result_dest_tag;
    logic      [num_fu-1:0][rob_w-1:0] result_rob_idx;
    alu_func_e [num_fu-1:0]           result_func;
    logic      [num_fu-1:0]           available;

    // expected port values per unit
    logic             model_ready = 1'b0;   // set at the first reset edge
    logic             exp_valid  [num_fu];
    logic [xlen-1:0]  exp_result [num_fu];
    logic [xlen-1:0]  pend       [num_fu];  // product waiting out the pipeline
    logic [tag_w-1:0] exp_tag    [num_fu];
    logic [rob_w-1:0] exp_rob    [num_fu];
    alu_func_e        exp_func   [num_fu];
    int               mult_cnt   [num_fu];  // edges left until the product lands

    integer seed = 32'h7b160a98;
    int     errors = 0;
    int     checks = 0;
    int     timeouts = 0;
    int     tag_ctr = 1;
    int     hold;
    string  test_name = "reset";

    alu_func_e alu_ops [num_ops] = '{alu_addq, alu_subq, alu_and, alu_bic, alu_bis, alu_ornot,
                                     alu_xor, alu_eqv, alu_srl, alu_sll, alu_sra, alu_cmpult,
                                     alu_cmpeq, alu_cmpule, alu_cmplt, alu_cmple};

    ex_stage #(
        .MULT_STAGES (mult_stages)
    ) ex_stage_inst (
        .clock           (clock),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_opa       (issue_opa),
        .issue_opb       (issue_opb),
        .issue_dest_tag  (issue_dest_tag),
        .issue_rob_idx   (issue_rob_idx),
        .issue_func      (issue_func),
        .grant           (grant),
        .result_valid    (result_valid),
        .result          (result),
        .result_dest_tag (result_dest_tag),
        .result_rob_idx  (result_rob_idx),
        .result_func     (result_func),
        .available       (available)
    );

    always #5 clock = ~clock;  // 10 ns period

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [xlen-1:0] ref_alu(input alu_func_e f, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        int sh;
        sh = int'(b[5:0]);  // low 6 bits only
        case (f)
            alu_addq:   return a + b;
            alu_subq:   return a - b;
            alu_and:    return a & b;
            alu_bic:    return a & ~b;
            alu_bis:    return a | b;
            alu_ornot:  return a | ~b;
            alu_xor:    return a ^ b;
            alu_eqv:    return ~(a ^ b);
            alu_srl:    return a >> sh;
            alu_sll:    return a << sh;
            alu_sra:    return $signed(a) >>> sh;
            alu_cmpult: return 64'(a < b);
            alu_cmpeq:  return 64'(a == b);
            alu_cmpule: return 64'(a <= b);
            alu_cmplt:  return 64'($signed(a) < $signed(b));
            alu_cmple:  return 64'($signed(a) <= $signed(b));
            default:    return '0;
        endcase
    endfunction

    // inputs read here are the values from before the edge
    always @(posedge clock)
    begin
        if (reset)
        begin
            model_ready <= 1'b1;
            for (int u = 0; u < num_fu; u++)
            begin
                exp_valid[u]  <= 1'b0;
                exp_result[u] <= '0;
                exp_tag[u]    <= '0;
                exp_rob[u]    <= '0;
                exp_func[u]   <= alu_default;
                mult_cnt[u]   <= 0;
            end
        end
        else
        begin
            for (int u = 0; u < num_fu; u++)
            begin
                if (issue_valid[u])
                begin
                    exp_tag[u]  <= issue_dest_tag[u];
                    exp_rob[u]  <= issue_rob_idx[u];
                    exp_func[u] <= issue_func[u];
                    if (u % 2 == 0)
                    begin
                        pend[u]      <= issue_opa[u] * issue_opb[u];  // low 64 bits
                        mult_cnt[u]  <= mult_stages + 1;
                        exp_valid[u] <= 1'b0;
                    end
                    else
                    begin
                        exp_result[u] <= ref_alu(issue_func[u], issue_opa[u], issue_opb[u]);
                        exp_valid[u]  <= 1'b1;
                    end
                end
                else if (grant[u])
                begin
                    exp_valid[u] <= 1'b0;
                end
                if (!issue_valid[u] && mult_cnt[u] > 1)
                begin
                    mult_cnt[u] <= mult_cnt[u] - 1;
                end
                else if (!issue_valid[u] && mult_cnt[u] == 1)
                begin
                    exp_result[u] <= pend[u];  // landing product wins over grant
                    exp_valid[u]  <= 1'b1;
                    mult_cnt[u]   <= 0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic check_field(input string what, input int u, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            errors++;
            $display("ERROR %s: unit %0d %s expected %h actual %h", test_name, u, what, exp, act);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clock)
    begin
        if (model_ready)
        begin
            for (int u = 0; u < num_fu; u++)
            begin
                check_field("result_valid", u, 64'(exp_valid[u]), 64'(result_valid[u]));
                check_field("available", u,
                            64'(exp_valid[u] ? grant[u] : (mult_cnt[u] == 0)),
                            64'(available[u]));
                check_field("result", u, exp_result[u], result[u]);
                check_field("dest_tag", u, 64'(exp_tag[u]), 64'(result_dest_tag[u]));
                check_field("rob_idx", u, 64'(exp_rob[u]), 64'(result_rob_idx[u]));
                check_field("func", u, 64'(exp_func[u]), 64'(result_func[u]));
            end
        end
    end

    // result_valid may only rise a fixed number of edges after an issue
    for (genvar g = 0; g < num_fu; g++)
    begin : g_latency
        localparam int lat = (g % 2 == 0) ? mult_stages + 2 : 1;  // rise seen one edge late

        assert property (@(posedge clock) disable iff (reset)
            $rose(result_valid[g]) |-> $past(issue_valid[g], lat))
        else
        begin
            errors++;
            $display("ERROR %s: unit %0d result_valid rose without an issue %0d edges before",
                     test_name, g, lat);
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [xlen-1:0] next_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic wait_idle(input int u);
        int n;
        n = 0;
        @(negedge clock);
        while (!(available[u] && !result_valid[u]))
        begin
            n++;
            if (n > timeout_cycles)
            begin
                timeouts++;
                $display("unit %0d never became idle in test %s", u, test_name);
                end_run();
            end
            @(negedge clock);
        end
    endtask

    task automatic wait_result(input int u);
        int n;
        n = 0;
        @(negedge clock);
        while (!result_valid[u])
        begin
            n++;
            if (n > timeout_cycles)
            begin
                timeouts++;
                $display("unit %0d never produced a result in test %s", u, test_name);
                end_run();
            end
            @(negedge clock);
        end
    endtask

    // call right after a rising edge with fresh tags each time
    task automatic load_issue(input int u, input alu_func_e f, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b);
        issue_valid[u]    <= 1'b1;
        issue_opa[u]      <= a;
        issue_opb[u]      <= b;
        issue_func[u]     <= f;
        issue_dest_tag[u] <= tag_w'(tag_ctr);
        issue_rob_idx[u]  <= rob_w'(tag_ctr * 3);
        tag_ctr++;
    endtask

    task automatic grant_unit(input int u);
        @(posedge clock);
        grant[u] <= 1'b1;
        @(posedge clock);
        grant[u] <= 1'b0;
    endtask

    // one op through one unit with an optional delay before the grant
    task automatic run_single(input int u, input alu_func_e f, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input int delay);
        wait_idle(u);
        @(posedge clock);
        load_issue(u, f, a, b);
        @(posedge clock);
        issue_valid[u] <= 1'b0;
        wait_result(u);
        repeat (delay) @(posedge clock);  // back-pressure
        grant_unit(u);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        reset          <= 1'b1;
        issue_valid    <= '0;
        issue_opa      <= '0;
        issue_opb      <= '0;
        issue_dest_tag <= '0;
        issue_rob_idx  <= '0;
        for (int u = 0; u < num_fu; u++)
        begin
            issue_func[u] <= alu_default;
        end
        grant          <= '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);

        // every alu op on both alu units with random and edge operands
        test_name = "alu_functions";
        for (int f = 0; f < num_ops; f++)
        begin
            run_single(1, alu_ops[f], next_word(), next_word(), 0);
            run_single(3, alu_ops[f], 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 0);
            run_single(1, alu_ops[f], {64{1'b1}}, next_word(), 0);
            run_single(3, alu_ops[f], 64'hdead_beef_0bad_f00d, 64'hdead_beef_0bad_f00d, 0);
            run_single(1, alu_ops[f], next_word() | 64'h8000_0000_0000_0000, 64'd63, 0);
            run_single(3, alu_ops[f], next_word(), 64'd0, 0);  // zero shift
        end

        test_name = "multiply";
        run_single(0, alu_default, {64{1'b1}}, {64{1'b1}}, 0);
        run_single(2, alu_addq, 64'h8000_0000_0000_0000, 64'd2, 0);
        for (int i = 0; i < 8; i++)
        begin
            run_single((i % 2) * 2, alu_ops[i], next_word(), next_word(), 0);
        end

        test_name = "back_pressure";
        for (int i = 0; i < 8; i++)
        begin
            hold = 1 + int'($unsigned($random(seed)) % 12);
            run_single(i % num_fu, alu_ops[(i * 5) % num_ops], next_word(), next_word(), hold);
        end

        // grant and reissue in the same cycle with no bubble
        test_name = "back_to_back";
        for (int u = 1; u < num_fu; u += 2)
        begin
            wait_idle(u);
            @(posedge clock);
            load_issue(u, alu_addq, next_word(), next_word());
            repeat (6)
            begin
                @(posedge clock);
                grant[u] <= 1'b1;
                load_issue(u, alu_ops[$unsigned($random(seed)) % num_ops], next_word(),
                           next_word());
            end
            @(posedge clock);
            issue_valid[u] <= 1'b0;
            grant[u]       <= 1'b0;
            wait_result(u);
            grant_unit(u);
        end

        // all four in one cycle with staggered grants
        test_name = "concurrent";
        for (int u = 0; u < num_fu; u++)
        begin
            wait_idle(u);
        end
        @(posedge clock);
        for (int u = 0; u < num_fu; u++)
        begin
            load_issue(u, alu_ops[u + 4], next_word(), next_word());
        end
        @(posedge clock);
        issue_valid <= '0;
        wait_result(1);
        grant_unit(1);
        wait_result(2);
        grant_unit(2);
        wait_result(3);  // held all this time
        grant_unit(3);
        wait_result(0);
        grant_unit(0);

        repeat (3) @(posedge clock);
        end_run();
    end

endmodule

`default_nettype wire

//--- ex_stage.f
ex_pkg.sv
fu_if.sv
alu.sv
mult.sv
exec_unit.sv
ex_stage.sv
ex_stage_tb.sv

//--- run.sh
#!/bin/sh
# builds with Verilator, runs the simulation, decides by a search of the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb \
    -f ex_stage.f -o ex_stage_sim > build.log 2>&1 &&
./obj_dir/ex_stage_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^test passed$" sim.log &&
echo "simulation result: pass" ||
{ echo "simulation result: fail, see sim.log"; exit 1; }
